/* logic/sram_stream_pkg.sv */
/*
 * SRAM streamer shared definitions
 * Default sizes for the top level, the address and word count types
 * and the state encoding of the read scheduler
 */
`default_nettype none

package sram_stream_pkg;

  // Defaults for the top-level parameters
  parameter int NUM_LANES_DEF  = 4;
  parameter int WR_WIDTH_DEF   = 128;
  parameter int RD_WIDTH_DEF   = 64;
  parameter int ADDR_WIDTH_DEF = 6;
  parameter int RD_LATENCY_DEF = 2;

  // Word address into one SRAM bank
  typedef logic [ADDR_WIDTH_DEF-1:0] addr_t;

  // Number of words in a request is one bit wider so a full bank fits
  typedef logic [ADDR_WIDTH_DEF:0] count_t;

  // Read scheduler states
  typedef enum logic [1:0] {
    SCHED_IDLE,
    SCHED_ISSUE,
    SCHED_WAIT_DRAIN
  } sched_state_t;

endpackage

`default_nettype wire

/* logic/sram_bank.sv */
/*
 * One lane's SRAM bank
 * Synchronous write port and a read path with a fixed latency
 * of RD_LATENCY cycles, pipelined so reads can overlap
 */
`timescale 1ns/10ps
`default_nettype none

module sram_bank #(
  parameter int WR_WIDTH   = sram_stream_pkg::WR_WIDTH_DEF,
  parameter int ADDR_WIDTH = sram_stream_pkg::ADDR_WIDTH_DEF,
  parameter int RD_LATENCY = sram_stream_pkg::RD_LATENCY_DEF
) (
  input  logic                   clk,
  input  logic                   rst_b,
  input  logic                   zeroize_i,
  input  logic                   wr_en_i,
  input  sram_stream_pkg::addr_t wr_addr_i,
  input  logic [WR_WIDTH-1:0]    wr_data_i,
  input  logic                   rd_en_i,
  input  sram_stream_pkg::addr_t rd_addr_i,
  output logic                   rd_valid_o,
  output logic [WR_WIDTH-1:0]    rd_data_o
);

  logic [WR_WIDTH-1:0]   mem_q [2**ADDR_WIDTH];
  logic [RD_LATENCY-1:0] rd_valid_q;
  logic [WR_WIDTH-1:0]   rd_data_q [RD_LATENCY];

  // Valid bits walk down the read pipeline and zeroize drops reads in flight
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      rd_valid_q <= '0;
    end else if (zeroize_i) begin
      rd_valid_q <= '0;
    end else begin
      rd_valid_q[0] <= rd_en_i;
      for (int i = 1; i < RD_LATENCY; i++) begin
        rd_valid_q[i] <= rd_valid_q[i-1];
      end
    end
  end

  // Array and read data stages follow the valid bits
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem_q[wr_addr_i] <= wr_data_i;
    end
    if (rd_en_i) begin
      rd_data_q[0] <= mem_q[rd_addr_i];
    end
    for (int i = 1; i < RD_LATENCY; i++) begin
      rd_data_q[i] <= rd_data_q[i-1];
    end
  end

  assign rd_valid_o = rd_valid_q[RD_LATENCY-1];
  assign rd_data_o  = rd_data_q[RD_LATENCY-1];

  // The array is single-ported so a read and a write never share a cycle
  a_no_rd_wr_collision: assert property (@(posedge clk) disable iff (!rst_b)
    !(rd_en_i && wr_en_i))
    else $error("sram_bank: read and write in the same cycle");

endmodule

`default_nettype wire

/* logic/abr_rd_lat_buffer.sv */
/*
 * Pre-allocated read latency buffer
 * Takes WR_WIDTH-bit writes and hands out RD_WIDTH-bit pieces as soon
 * as enough bits are held. Space is reserved at SRAM read time, so
 * there is no full flag and no back-pressure toward the bank
 */
`timescale 1ns/10ps
`default_nettype none

module abr_rd_lat_buffer #(
  parameter int WR_WIDTH     = sram_stream_pkg::WR_WIDTH_DEF,
  parameter int RD_WIDTH     = sram_stream_pkg::RD_WIDTH_DEF,
  parameter int BUFFER_DEPTH = WR_WIDTH + RD_WIDTH
) (
  input  logic                clk,
  input  logic                rst_b,
  input  logic                zeroize_i,
  input  logic                data_valid_i,
  input  logic [WR_WIDTH-1:0] data_i,
  output logic                data_valid_o,
  output logic [RD_WIDTH-1:0] data_o
);

  // Pointer is wide enough to show an overflow past BUFFER_DEPTH
  localparam int PTR_W = $clog2(BUFFER_DEPTH + WR_WIDTH + 1);

  logic [BUFFER_DEPTH-1:0] buf_q;
  logic [BUFFER_DEPTH-1:0] buf_d;
  logic [BUFFER_DEPTH-1:0] buf_shifted;
  logic [BUFFER_DEPTH-1:0] wr_placed;
  logic [PTR_W-1:0]        wr_ptr_q;
  logic [PTR_W-1:0]        wr_ptr_d;
  logic [PTR_W-1:0]        wr_pos;
  logic                    buf_rd;
  logic                    buf_wr;

  // A piece leaves whenever a full RD_WIDTH is held
  assign buf_rd = wr_ptr_q >= PTR_W'(RD_WIDTH);
  assign buf_wr = data_valid_i;

  always_comb begin
    // With a read in the same cycle the new data lands one piece lower
    wr_pos = buf_rd ? wr_ptr_q - PTR_W'(RD_WIDTH) : wr_ptr_q;
    wr_ptr_d = wr_pos;
    if (buf_wr) begin
      wr_ptr_d = wr_pos + PTR_W'(WR_WIDTH);
    end

    // Drop the outgoing piece, then OR the incoming word in above the held bits
    buf_shifted = buf_rd ? buf_q >> RD_WIDTH : buf_q;
    wr_placed   = buf_wr ? BUFFER_DEPTH'(data_i) << wr_pos : '0;
    buf_d       = buf_shifted | wr_placed;
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      buf_q    <= '0;
      wr_ptr_q <= '0;
    end else if (zeroize_i) begin
      buf_q    <= '0;
      wr_ptr_q <= '0;
    end else if (buf_rd || buf_wr) begin
      buf_q    <= buf_d;
      wr_ptr_q <= wr_ptr_d;
    end
  end

  // Lowest bits go out first
  assign data_valid_o = buf_rd & ~zeroize_i;
  assign data_o       = buf_q[RD_WIDTH-1:0];

  // The scheduler's allocation must keep every write inside the buffer
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_b || zeroize_i)
    wr_ptr_d <= PTR_W'(BUFFER_DEPTH))
    else $error("abr_rd_lat_buffer: write pointer past BUFFER_DEPTH");

endmodule

`default_nettype wire

/* logic/read_scheduler.sv */
/*
 * Read scheduler
 * Turns a block request into one read per cycle to all banks at once.
 * Buffer space is reserved per read and given back per drained piece,
 * and a read waits while the reservation would not fit
 */
`timescale 1ns/10ps
`default_nettype none

module read_scheduler #(
  parameter int WR_WIDTH     = sram_stream_pkg::WR_WIDTH_DEF,
  parameter int RD_WIDTH     = sram_stream_pkg::RD_WIDTH_DEF,
  parameter int BUFFER_DEPTH = WR_WIDTH + RD_WIDTH
) (
  input  logic                    clk,
  input  logic                    rst_b,
  input  logic                    zeroize_i,
  input  logic                    start_i,
  input  sram_stream_pkg::addr_t  base_addr_i,
  input  sram_stream_pkg::count_t num_words_i,
  input  logic                    drain_i,
  input  logic                    last_i,
  output logic                    rd_en_o,
  output sram_stream_pkg::addr_t  rd_addr_o,
  output logic                    busy_o
);

  import sram_stream_pkg::*;

  localparam int ALLOC_W = $clog2(BUFFER_DEPTH + WR_WIDTH + 1);

  sched_state_t       state_q;
  addr_t              addr_q;
  count_t             words_left_q;
  logic [ALLOC_W-1:0] alloc_q;
  logic [ALLOC_W-1:0] alloc_d;
  logic               room;
  logic               issue;

  // Every lane's buffer fills alike, so one count covers them all
  assign room  = (alloc_q + ALLOC_W'(WR_WIDTH)) <= ALLOC_W'(BUFFER_DEPTH);
  assign issue = (state_q == SCHED_ISSUE) && room && !zeroize_i;

  always_comb begin
    alloc_d = alloc_q;
    if (issue) begin
      alloc_d = alloc_d + ALLOC_W'(WR_WIDTH);
    end
    if (drain_i) begin
      alloc_d = alloc_d - ALLOC_W'(RD_WIDTH);
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state_q      <= SCHED_IDLE;
      addr_q       <= '0;
      words_left_q <= '0;
      alloc_q      <= '0;
    end else if (zeroize_i) begin
      state_q      <= SCHED_IDLE;
      words_left_q <= '0;
      alloc_q      <= '0;
    end else begin
      alloc_q <= alloc_d;
      case (state_q)
        SCHED_IDLE: begin
          // Requests are only taken here so a start while busy falls through
          if (start_i) begin
            addr_q       <= base_addr_i;
            words_left_q <= num_words_i;
            state_q      <= SCHED_ISSUE;
          end
        end
        SCHED_ISSUE: begin
          if (issue) begin
            // Address wraps at the top of the bank
            addr_q       <= addr_q + 1'b1;
            words_left_q <= words_left_q - 1'b1;
            if (words_left_q == count_t'(1)) begin
              state_q <= SCHED_WAIT_DRAIN;
            end
          end
        end
        SCHED_WAIT_DRAIN: begin
          // Back to idle in the done cycle so the next start is taken there
          if (last_i) begin
            state_q <= SCHED_IDLE;
          end
        end
        default: state_q <= SCHED_IDLE;
      endcase
    end
  end

  assign rd_en_o   = issue;
  assign rd_addr_o = addr_q;
  assign busy_o    = state_q != SCHED_IDLE;

  // Drains only return space that an earlier read reserved
  a_alloc_no_underflow: assert property (@(posedge clk) disable iff (!rst_b || zeroize_i)
    drain_i |-> alloc_q >= ALLOC_W'(RD_WIDTH))
    else $error("read_scheduler: allocated count would go negative");

endmodule

`default_nettype wire

/* logic/stream_collector.sv */
/*
 * Stream collector
 * Joins the lane pieces into output words, returns a drain pulse
 * per piece and counts the block down to its last piece and done
 */
`timescale 1ns/10ps
`default_nettype none

module stream_collector #(
  parameter int NUM_LANES = sram_stream_pkg::NUM_LANES_DEF,
  parameter int WR_WIDTH  = sram_stream_pkg::WR_WIDTH_DEF,
  parameter int RD_WIDTH  = sram_stream_pkg::RD_WIDTH_DEF
) (
  input  logic                          clk,
  input  logic                          rst_b,
  input  logic                          zeroize_i,
  input  logic                          start_i,
  input  sram_stream_pkg::count_t       num_words_i,
  input  logic [NUM_LANES-1:0]          lane_valid_i,
  input  logic [NUM_LANES*RD_WIDTH-1:0] lane_data_i,
  output logic                          data_valid_o,
  output logic [NUM_LANES*RD_WIDTH-1:0] data_o,
  output logic                          drain_o,
  output logic                          last_o,
  output logic                          done_o
);

  import sram_stream_pkg::*;

  localparam int PIECES_PER_WORD = WR_WIDTH / RD_WIDTH;
  localparam int PCNT_W          = $bits(count_t) + $clog2(PIECES_PER_WORD);

  logic [PCNT_W-1:0] pieces_left_q;
  logic              done_q;

  // Lanes run in lock-step, so lane 0 speaks for all of them
  assign data_valid_o = lane_valid_i[0];
  assign drain_o      = lane_valid_i[0];
  assign data_o       = lane_data_i;
  assign last_o       = lane_valid_i[0] && (pieces_left_q == PCNT_W'(1));

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      pieces_left_q <= '0;
      done_q        <= 1'b0;
    end else if (zeroize_i) begin
      pieces_left_q <= '0;
      done_q        <= 1'b0;
    end else begin
      done_q <= last_o;
      // A zero count means no block is open and matches an idle scheduler
      if (start_i && (pieces_left_q == '0)) begin
        pieces_left_q <= PCNT_W'(num_words_i) * PCNT_W'(PIECES_PER_WORD);
      end else if (lane_valid_i[0]) begin
        pieces_left_q <= pieces_left_q - 1'b1;
      end
    end
  end

  assign done_o = done_q;

  // All lanes must deliver their piece in the same cycle
  a_lanes_aligned: assert property (@(posedge clk) disable iff (!rst_b)
    (&lane_valid_i) || !(|lane_valid_i))
    else $error("stream_collector: lane valids disagree");

endmodule

`default_nettype wire

/* logic/sram_streamer.sv */
/*
 * Banked SRAM streamer
 * Scheduler, NUM_LANES bank and latency buffer pairs, and the collector
 * that turns their pieces into one output stream
 */
`timescale 1ns/10ps
`default_nettype none

module sram_streamer #(
  parameter int NUM_LANES    = sram_stream_pkg::NUM_LANES_DEF,
  parameter int WR_WIDTH     = sram_stream_pkg::WR_WIDTH_DEF,
  parameter int RD_WIDTH     = sram_stream_pkg::RD_WIDTH_DEF,
  parameter int ADDR_WIDTH   = sram_stream_pkg::ADDR_WIDTH_DEF,
  parameter int RD_LATENCY   = sram_stream_pkg::RD_LATENCY_DEF,
  parameter int BUFFER_DEPTH = WR_WIDTH + RD_WIDTH
) (
  input  logic                          clk,
  input  logic                          rst_b,
  input  logic                          zeroize_i,
  input  logic                          wr_en_i,
  input  sram_stream_pkg::addr_t        wr_addr_i,
  input  logic [NUM_LANES*WR_WIDTH-1:0] wr_data_i,
  input  logic                          start_i,
  input  sram_stream_pkg::addr_t        base_addr_i,
  input  sram_stream_pkg::count_t       num_words_i,
  output logic                          busy_o,
  output logic                          data_valid_o,
  output logic [NUM_LANES*RD_WIDTH-1:0] data_o,
  output logic                          done_o
);

  import sram_stream_pkg::*;

  logic                          rd_en;
  addr_t                         rd_addr;
  logic                          drain;
  logic                          last;
  logic [NUM_LANES-1:0]          bank_valid;
  logic [NUM_LANES*WR_WIDTH-1:0] bank_data;
  logic [NUM_LANES-1:0]          lane_valid;
  logic [NUM_LANES*RD_WIDTH-1:0] lane_data;

  read_scheduler #(
    .WR_WIDTH     (WR_WIDTH),
    .RD_WIDTH     (RD_WIDTH),
    .BUFFER_DEPTH (BUFFER_DEPTH)
  ) read_scheduler_i (
    .clk         (clk),
    .rst_b       (rst_b),
    .zeroize_i   (zeroize_i),
    .start_i     (start_i),
    .base_addr_i (base_addr_i),
    .num_words_i (num_words_i),
    .drain_i     (drain),
    .last_i      (last),
    .rd_en_o     (rd_en),
    .rd_addr_o   (rd_addr),
    .busy_o      (busy_o)
  );

  // Lane l owns slice l of every SRAM word
  for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
    sram_bank #(
      .WR_WIDTH   (WR_WIDTH),
      .ADDR_WIDTH (ADDR_WIDTH),
      .RD_LATENCY (RD_LATENCY)
    ) sram_bank_i (
      .clk        (clk),
      .rst_b      (rst_b),
      .zeroize_i  (zeroize_i),
      .wr_en_i    (wr_en_i),
      .wr_addr_i  (wr_addr_i),
      .wr_data_i  (wr_data_i[l*WR_WIDTH +: WR_WIDTH]),
      .rd_en_i    (rd_en),
      .rd_addr_i  (rd_addr),
      .rd_valid_o (bank_valid[l]),
      .rd_data_o  (bank_data[l*WR_WIDTH +: WR_WIDTH])
    );

    abr_rd_lat_buffer #(
      .WR_WIDTH     (WR_WIDTH),
      .RD_WIDTH     (RD_WIDTH),
      .BUFFER_DEPTH (BUFFER_DEPTH)
    ) abr_rd_lat_buffer_i (
      .clk          (clk),
      .rst_b        (rst_b),
      .zeroize_i    (zeroize_i),
      .data_valid_i (bank_valid[l]),
      .data_i       (bank_data[l*WR_WIDTH +: WR_WIDTH]),
      .data_valid_o (lane_valid[l]),
      .data_o       (lane_data[l*RD_WIDTH +: RD_WIDTH])
    );
  end

  stream_collector #(
    .NUM_LANES (NUM_LANES),
    .WR_WIDTH  (WR_WIDTH),
    .RD_WIDTH  (RD_WIDTH)
  ) stream_collector_i (
    .clk          (clk),
    .rst_b        (rst_b),
    .zeroize_i    (zeroize_i),
    .start_i      (start_i),
    .num_words_i  (num_words_i),
    .lane_valid_i (lane_valid),
    .lane_data_i  (lane_data),
    .data_valid_o (data_valid_o),
    .data_o       (data_o),
    .drain_o      (drain),
    .last_o       (last),
    .done_o       (done_o)
  );

  // Loading the SRAM is only legal between blocks
  a_write_when_idle: assert property (@(posedge clk) disable iff (!rst_b)
    wr_en_i |-> !busy_o)
    else $error("sram_streamer: SRAM write while busy");

endmodule

`default_nettype wire

/* tests/sram_streamer_tb.sv */
/*
 * Banked SRAM streamer testbench
 * Loads the banks from an LFSR model, streams directed blocks and checks
 * every piece, the first-piece latency, done and busy against the model
 */
`timescale 1ns/10ps
`default_nettype none

module sram_streamer_tb;

  import sram_stream_pkg::*;

  localparam int NUM_LANES  = NUM_LANES_DEF;
  localparam int WR_WIDTH   = WR_WIDTH_DEF;
  localparam int RD_WIDTH   = RD_WIDTH_DEF;
  localparam int RD_LATENCY = RD_LATENCY_DEF;
  localparam int BANK_WORDS = 2**ADDR_WIDTH_DEF;
  localparam int PIECES     = WR_WIDTH / RD_WIDTH;
  localparam int IN_W       = NUM_LANES * WR_WIDTH;
  localparam int OUT_W      = NUM_LANES * RD_WIDTH;
  localparam int CLK_PERIOD = 40;
  // Words over all tests at about 4 cycles each, with loading and idle checks in the margin
  localparam int TOTAL_WORDS   = 1 + 40 + 3 + 5 + 6 + 20 + 4 + 8;
  localparam int MARGIN_CYCLES = 600;
  localparam int WATCHDOG_NS   = (TOTAL_WORDS * 4 + MARGIN_CYCLES) * CLK_PERIOD;

  logic             clk;
  logic             rst_b;
  logic             zeroize_i;
  logic             wr_en_i;
  addr_t            wr_addr_i;
  logic [IN_W-1:0]  wr_data_i;
  logic             start_i;
  addr_t            base_addr_i;
  count_t           num_words_i;
  logic             busy_o;
  logic             data_valid_o;
  logic [OUT_W-1:0] data_o;
  logic             done_o;

  logic [IN_W-1:0] model_mem [BANK_WORDS];
  logic [31:0]     lfsr_q;
  int              checks;
  int              errors;

  sram_streamer sram_streamer_i (
    .clk          (clk),
    .rst_b        (rst_b),
    .zeroize_i    (zeroize_i),
    .wr_en_i      (wr_en_i),
    .wr_addr_i    (wr_addr_i),
    .wr_data_i    (wr_data_i),
    .start_i      (start_i),
    .base_addr_i  (base_addr_i),
    .num_words_i  (num_words_i),
    .busy_o       (busy_o),
    .data_valid_o (data_valid_o),
    .data_o       (data_o),
    .done_o       (done_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // Piece idx of a block takes part idx%PIECES of every lane slice of word base+idx/PIECES
  function automatic logic [OUT_W-1:0] expected_piece(input addr_t base, input int idx);
    logic [OUT_W-1:0] p;
    addr_t            a;
    int               part;
    a    = base + addr_t'(idx / PIECES);
    part = idx % PIECES;
    for (int l = 0; l < NUM_LANES; l++) begin
      p[l*RD_WIDTH +: RD_WIDTH] = model_mem[a][l*WR_WIDTH + part*RD_WIDTH +: RD_WIDTH];
    end
    return p;
  endfunction

  task automatic expect_true(input bit cond, input string msg);
    checks++;
    assert (cond) else begin
      errors++;
      $display("FAILED at %0t ns: %s", $time, msg);
    end
  endtask

  task automatic fill_and_load_memory();
    for (int a = 0; a < BANK_WORDS; a++) begin
      for (int b = 0; b < IN_W; b++) begin
        lfsr_q = lfsr_step(lfsr_q);
        model_mem[a][b] = lfsr_q[0];
      end
    end
    for (int a = 0; a < BANK_WORDS; a++) begin
      @(posedge clk);
      wr_en_i   <= 1'b1;
      wr_addr_i <= addr_t'(a);
      wr_data_i <= model_mem[a];
    end
    @(posedge clk);
    wr_en_i <= 1'b0;
  endtask

  task automatic drive_start(input addr_t base, input int nwords);
    @(posedge clk);
    start_i     <= 1'b1;
    base_addr_i <= base;
    num_words_i <= count_t'(nwords);
  endtask

  // Runs one edge after drive_start and collects pieces up to done_o
  // With chain set the next request is driven so it lands in the done cycle
  task automatic collect_block(input addr_t base, input int nwords, input bit check_lat,
                               input bit chain, input addr_t next_base, input int next_words);
    logic [OUT_W-1:0] pieces [$];
    int               expected;
    int               cycle;
    int               first_cycle;
    int               last_cycle;
    bit               chained;
    bit               finished;
    expected    = nwords * PIECES;
    cycle       = 0;
    first_cycle = -1;
    last_cycle  = -1;
    chained     = 1'b0;
    finished    = 1'b0;
    // The DUT samples the start at this edge
    @(posedge clk);
    start_i <= 1'b0;
    while (!finished) begin
      @(negedge clk);
      cycle++;
      if (data_valid_o) begin
        if (first_cycle < 0) begin
          first_cycle = cycle;
        end
        last_cycle = cycle;
        pieces.push_back(data_o);
      end
      if (done_o) begin
        finished = 1'b1;
        expect_true(!busy_o, "busy_o still high in the done_o cycle");
        expect_true(cycle == last_cycle + 1,
                    $sformatf("done_o in cycle %0d, last piece in %0d", cycle, last_cycle));
      end else begin
        expect_true(busy_o, $sformatf("busy_o low in cycle %0d of a block", cycle));
      end
      // The next start goes out at the coming edge and so lands in the done cycle
      if (chain && !chained && pieces.size() == expected) begin
        chained = 1'b1;
        drive_start(next_base, next_words);
      end
    end
    expect_true(pieces.size() == expected,
                $sformatf("got %0d pieces, expected %0d", pieces.size(), expected));
    if (check_lat) begin
      expect_true(first_cycle == RD_LATENCY + 2,
                  $sformatf("first piece after %0d cycles", first_cycle));
    end
    for (int i = 0; i < pieces.size() && i < expected; i++) begin
      expect_true(pieces[i] === expected_piece(base, i),
                  $sformatf("piece %0d of block at %0d is %h", i, base, pieces[i]));
    end
  endtask

  task automatic check_idle(input int ncycles, input string what);
    repeat (ncycles) begin
      @(negedge clk);
      expect_true(!data_valid_o && !done_o && !busy_o,
                  $sformatf("%s: valid %b done %b busy %b", what, data_valid_o, done_o, busy_o));
    end
  endtask

  task automatic run_block(input addr_t base, input int nwords, input bit check_lat);
    drive_start(base, nwords);
    collect_block(base, nwords, check_lat, 1'b0, '0, 0);
    check_idle(4, "after block");
  endtask

  task automatic back_to_back_blocks();
    drive_start(6'd5, 3);
    collect_block(6'd5, 3, 1'b0, 1'b1, 6'd20, 5);
    collect_block(6'd20, 5, 1'b0, 1'b0, '0, 0);
    check_idle(4, "after chained blocks");
  endtask

  // A one-word request to address 0 while busy must leave the stream untouched
  task automatic start_while_busy();
    drive_start(6'd30, 6);
    fork
      collect_block(6'd30, 6, 1'b0, 1'b0, '0, 0);
      begin
        repeat (3) @(posedge clk);
        @(negedge clk);
        expect_true(busy_o, "busy_o low during a block");
        @(posedge clk);
        start_i     <= 1'b1;
        base_addr_i <= '0;
        num_words_i <= count_t'(1);
        @(posedge clk);
        start_i <= 1'b0;
      end
    join
    check_idle(8, "after ignored start");
  endtask

  task automatic zeroize_mid_stream();
    int seen;
    seen = 0;
    drive_start(6'd12, 20);
    @(posedge clk);
    start_i <= 1'b0;
    while (seen < 6) begin
      @(negedge clk);
      if (data_valid_o) begin
        expect_true(data_o === expected_piece(6'd12, seen),
                    $sformatf("piece %0d before zeroize is %h", seen, data_o));
        seen++;
      end
    end
    @(posedge clk);
    zeroize_i <= 1'b1;
    @(posedge clk);
    zeroize_i <= 1'b0;
    check_idle(12, "after zeroize");
    // Nothing of the aborted block may leak into the next one
    run_block(6'd40, 4, 1'b1);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired, the DUT stopped responding");
    $display("Regression failed");
    $finish;
  end

  initial begin
    checks      = 0;
    errors      = 0;
    lfsr_q      = 32'h9b36_b075;
    rst_b       <= 1'b0;
    zeroize_i   <= 1'b0;
    wr_en_i     <= 1'b0;
    wr_addr_i   <= '0;
    wr_data_i   <= '0;
    start_i     <= 1'b0;
    base_addr_i <= '0;
    num_words_i <= '0;
    repeat (3) @(posedge clk);
    rst_b <= 1'b1;

    fill_and_load_memory();
    run_block(6'd9, 1, 1'b1);
    run_block(6'd17, 40, 1'b0);
    back_to_back_blocks();
    start_while_busy();
    // Crosses the top of the bank and wraps to address 0
    run_block(6'd60, 8, 1'b0);
    zeroize_mid_stream();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vlog.f */
logic/sram_stream_pkg.sv
logic/sram_bank.sv
logic/abr_rd_lat_buffer.sv
logic/read_scheduler.sv
logic/stream_collector.sv
logic/sram_streamer.sv
tests/sram_streamer_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := sram_streamer_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
PASS_MSG  := Regression passed

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
